/* common/mipsPkg.sv */
package mipsPkg;

    // Machine word and register index widths
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // First fetch after reset
    localparam wordT resetVector = 32'hBFC00000;
    // A fetch from here ends the run
    localparam wordT haltAddress = 32'h00000000;
    // Return value register, reported on register_v0
    localparam regAddrT v0Index = 5'd2;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcodeT;

    // Function codes of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } cpuStateT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOpT;

endpackage

/* common/regPortIf.sv */
`timescale 1ns/1ps

interface regPortIf import mipsPkg::*; ();

    // Two combinational read ports
    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT rsData;
    wordT rtData;

    // One write port, taken at the clock edge
    logic writeEn;
    regAddrT writeAddr;
    wordT writeData;

    modport ctrl (
        output rsAddr, rtAddr, writeEn, writeAddr, writeData,
        input rsData, rtData
    );

    modport regs (
        input rsAddr, rtAddr, writeEn, writeAddr, writeData,
        output rsData, rtData
    );

endinterface

/* core/alu.sv */
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input aluOpT aluOp,
    input wordT aluA,
    input wordT aluB,
    input logic [4:0] shamt,
    output wordT result,
    output logic equal
);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = aluA + aluB;
            ALU_SUB: result = aluA - aluB;
            ALU_AND: result = aluA & aluB;
            ALU_OR:  result = aluA | aluB;
            ALU_XOR: result = aluA ^ aluB;
            // Set-on-less-than gives one or zero
            ALU_SLT: begin
                result = ($signed(aluA) < $signed(aluB)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                result = (aluA < aluB) ? 32'd1 : 32'd0;
            end
            // Shifts act on the rt operand
            ALU_SLL: result = aluB << shamt;
            ALU_SRL: result = aluB >> shamt;
            ALU_SRA: result = $signed(aluB) >>> shamt;
            // Immediate into the upper half
            ALU_LUI: result = {aluB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // Branch compare of rs and rt
    assign equal = (aluA == aluB);

endmodule

/* core/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl import mipsPkg::*; (
    input logic clk,
    input logic reset,
    input logic waitrequest,
    input wordT readWord,
    input wordT aluResult,
    input logic aluEqual,
    regPortIf.ctrl regs,
    output logic fetchReq,
    output logic loadReq,
    output logic storeReq,
    output wordT pc,
    output wordT dataAddr,
    output wordT storeValue,
    output aluOpT aluOp,
    output wordT aluA,
    output wordT aluB,
    output logic [4:0] shamt,
    output logic active,
    output wordT registerV0
);

    cpuStateT state;
    cpuStateT nextState;
    logic running;
    logic jumpPending;
    wordT jumpTarget;
    wordT ir;
    wordT opA;
    wordT opB;
    wordT aluOut;

    opcodeT opcode;
    functT funct;
    regAddrT irRs;
    regAddrT irRt;
    regAddrT irRd;
    wordT signExt;
    wordT zeroExt;
    wordT pcPlus4;
    wordT branchTarget;
    wordT nextPc;
    wordT jumpDest;
    logic isLoad;
    logic isStore;
    logic writesReg;
    logic takeJump;
    logic instrDone;

    // Instruction fields
    assign opcode = opcodeT'(ir[31:26]);
    assign funct = functT'(ir[5:0]);
    assign irRs = ir[25:21];
    assign irRt = ir[20:16];
    assign irRd = ir[15:11];
    assign shamt = ir[10:6];
    assign signExt = {{16{ir[15]}}, ir[15:0]};
    assign zeroExt = {16'h0000, ir[15:0]};

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signExt[29:0], 2'b00};
    // Delay slot done, so a pending jump takes over
    assign nextPc = jumpPending ? jumpTarget : pcPlus4;

    assign isLoad = (opcode == OP_LW);
    assign isStore = (opcode == OP_SW);

    // Bus requests; nothing is fetched until the first cycle out of reset
    assign fetchReq = (state == FETCH) && running;
    assign loadReq = (state == MEMORY) && isLoad;
    assign storeReq = (state == MEMORY) && isStore;
    assign dataAddr = aluOut;
    assign storeValue = opB;
    assign aluA = opA;

    // Register file access, v0 is read once the core has stopped
    assign regs.rsAddr = (state == HALTED) ? v0Index : irRs;
    assign regs.rtAddr = irRt;
    assign regs.writeEn = (state == WRITEBACK);
    assign regs.writeAddr = (opcode == OP_SPECIAL) ? irRd : irRt;
    assign regs.writeData = aluOut;

    // Operation and second operand
    always_comb begin
        aluOp = ALU_ADD;
        aluB = signExt;
        writesReg = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                aluB = opB;
                writesReg = 1'b1;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    // JR and unknown codes write nothing
                    default: writesReg = 1'b0;
                endcase
            end
            OP_ADDIU: writesReg = 1'b1;
            OP_SLTI: begin
                aluOp = ALU_SLT;
                writesReg = 1'b1;
            end
            OP_SLTIU: begin
                aluOp = ALU_SLTU;
                writesReg = 1'b1;
            end
            OP_ANDI: begin
                aluOp = ALU_AND;
                aluB = zeroExt;
                writesReg = 1'b1;
            end
            OP_ORI: begin
                aluOp = ALU_OR;
                aluB = zeroExt;
                writesReg = 1'b1;
            end
            OP_XORI: begin
                aluOp = ALU_XOR;
                aluB = zeroExt;
                writesReg = 1'b1;
            end
            OP_LUI: begin
                aluOp = ALU_LUI;
                writesReg = 1'b1;
            end
            OP_BEQ, OP_BNE: aluB = opB;
            default: ;
        endcase
    end

    // Branch and jump decision, used at the end of EXECUTE
    always_comb begin
        takeJump = 1'b0;
        jumpDest = branchTarget;
        case (opcode)
            OP_BEQ: takeJump = aluEqual;
            OP_BNE: takeJump = !aluEqual;
            OP_J: begin
                takeJump = 1'b1;
                jumpDest = {pcPlus4[31:28], ir[25:0], 2'b00};
            end
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    takeJump = 1'b1;
                    jumpDest = opA;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        nextState = state;
        instrDone = 1'b0;
        case (state)
            FETCH: begin
                if (fetchReq && !waitrequest) begin
                    nextState = DECODE;
                end
            end
            DECODE: nextState = EXECUTE;
            EXECUTE: begin
                if (isLoad || isStore) begin
                    nextState = MEMORY;
                end else if (writesReg) begin
                    nextState = WRITEBACK;
                end else begin
                    instrDone = 1'b1;
                end
            end
            MEMORY: begin
                if (!waitrequest) begin
                    if (isLoad) begin
                        nextState = WRITEBACK;
                    end else begin
                        instrDone = 1'b1;
                    end
                end
            end
            WRITEBACK: instrDone = 1'b1;
            default: ;
        endcase
        if (instrDone) begin
            nextState = (nextPc == haltAddress) ? HALTED : FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            running <= 1'b0;
            pc <= resetVector;
            jumpPending <= 1'b0;
            active <= 1'b1;
            registerV0 <= '0;
        end else begin
            state <= nextState;
            running <= 1'b1;
            if (instrDone) begin
                pc <= nextPc;
                jumpPending <= (state == EXECUTE) && takeJump;
            end
            if ((state == HALTED) && active) begin
                active <= 1'b0;
                registerV0 <= regs.rsData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq && !waitrequest) begin
            ir <= readWord;
        end
        if (state == DECODE) begin
            opA <= regs.rsData;
            opB <= regs.rtData;
        end
        if (state == EXECUTE) begin
            aluOut <= aluResult;
        end
        if ((state == EXECUTE) && takeJump) begin
            jumpTarget <= jumpDest;
        end
        // Load data shares the result register on its way to write-back
        if (loadReq && !waitrequest) begin
            aluOut <= readWord;
        end
    end

    memReqExclusive: assert property (@(posedge clk) disable iff (reset)
        !(loadReq && storeReq));

    // Avalon hold rule on fetch
    fetchHeld: assert property (@(posedge clk) disable iff (reset)
        fetchReq && waitrequest |=> fetchReq && $stable(pc));

endmodule

/* core/memPort.sv */
`timescale 1ns/1ps

module memPort import mipsPkg::*; (
    input logic clk,
    input logic fetchReq,
    input logic loadReq,
    input logic storeReq,
    input wordT pc,
    input wordT dataAddr,
    input wordT storeValue,
    input wordT readdata,
    output wordT address,
    output logic read,
    output logic write,
    output wordT writedata,
    output logic [3:0] byteenable,
    output wordT readWord
);

    // Bus words are byte-reversed against register values
    function automatic wordT swapBytes(input wordT word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    assign address = fetchReq ? pc : dataAddr;
    assign read = fetchReq || loadReq;
    assign write = storeReq;

    assign writedata = swapBytes(storeValue);
    assign readWord = swapBytes(readdata);

    // Word accesses only
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    // Fetch and store come from different states of the control FSM
    readWriteExclusive: assert property (@(posedge clk) !(read && write));

endmodule

/* core/regFile.sv */
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input logic clk,
    input logic reset,
    regPortIf.regs port
);

    wordT storage [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                storage[i] <= '0;
            end
        end else if (port.writeEn && (port.writeAddr != '0)) begin
            storage[port.writeAddr] <= port.writeData;
        end
    end

    // Register zero always reads as zero
    assign port.rsData = (port.rsAddr == '0) ? '0 : storage[port.rsAddr];
    assign port.rtData = (port.rtAddr == '0) ? '0 : storage[port.rtAddr];

endmodule

/* filelist.f */
common/mipsPkg.sv
common/regPortIf.sv
core/alu.sv
core/regFile.sv
core/memPort.sv
core/cpuControl.sv
rtl/mipsCpuBus.sv
test/busMemory.sv
test/mipsCpuBusTb.sv

/* rtl/mipsCpuBus.sv */
`timescale 1ns/1ps

module mipsCpuBus import mipsPkg::*; (
    input logic clk,
    input logic reset,
    output logic active,
    output wordT register_v0,

    // Avalon master
    output wordT address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output wordT writedata,
    output logic [3:0] byteenable,
    input wordT readdata
);

    logic fetchReq;
    logic loadReq;
    logic storeReq;
    wordT pc;
    wordT dataAddr;
    wordT storeValue;
    wordT readWord;
    aluOpT aluOp;
    wordT aluA;
    wordT aluB;
    logic [4:0] shamt;
    wordT aluResult;
    logic aluEqual;

    regPortIf regBus ();

    cpuControl control (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .readWord(readWord),
        .aluResult(aluResult),
        .aluEqual(aluEqual),
        .regs(regBus),
        .fetchReq(fetchReq),
        .loadReq(loadReq),
        .storeReq(storeReq),
        .pc(pc),
        .dataAddr(dataAddr),
        .storeValue(storeValue),
        .aluOp(aluOp),
        .aluA(aluA),
        .aluB(aluB),
        .shamt(shamt),
        .active(active),
        .registerV0(register_v0)
    );

    regFile registers (
        .clk(clk),
        .reset(reset),
        .port(regBus)
    );

    alu arith (
        .aluOp(aluOp),
        .aluA(aluA),
        .aluB(aluB),
        .shamt(shamt),
        .result(aluResult),
        .equal(aluEqual)
    );

    memPort bus (
        .clk(clk),
        .fetchReq(fetchReq),
        .loadReq(loadReq),
        .storeReq(storeReq),
        .pc(pc),
        .dataAddr(dataAddr),
        .storeValue(storeValue),
        .readdata(readdata),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .readWord(readWord)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module mipsCpuBusTb -o simv
output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

/* test/busMemory.sv */
`timescale 1ns/1ps

module busMemory (
    input logic clk,
    input logic stallEnable,
    input logic [31:0] address,
    input logic read,
    input logic write,
    input logic [31:0] writedata,
    input logic [3:0] byteenable,
    output logic waitrequest,
    output logic [31:0] readdata
);

    // Sparse word store by byte address, held in bus byte order
    logic [31:0] storage [logic [31:0]];
    logic [31:0] expectAddr;
    logic [31:0] expectData;
    logic expectValid = 1'b0;
    int seed = 1199;
    int errorCount = 0;

    function automatic logic [31:0] reverseBytes(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    // Unwritten words read back as a pattern of their address
    function automatic logic [31:0] wordAt(input logic [31:0] addr);
        return storage.exists(addr) ? storage[addr] : (addr ^ 32'h5A5A5A5A);
    endfunction

    task automatic clear();
        storage.delete();
        expectValid = 1'b0;
    endtask

    task automatic loadWord(input logic [31:0] addr, input logic [31:0] value);
        storage[addr] = reverseBytes(value);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] value,
                               input logic valid);
        expectAddr = addr;
        expectData = value;
        expectValid = valid;
    endtask

    initial begin
        waitrequest = 1'b0;
        readdata = '0;
        forever begin
            @(posedge clk);
            if (read || write) begin
                assert (byteenable == 4'b1111) else begin
                    $display("CHECK FAILED at %0t: byteenable %b", $time, byteenable);
                    errorCount++;
                end
            end
            // Store completes on this edge
            if (write && !waitrequest) begin
                assert (expectValid && address == expectAddr
                        && writedata == reverseBytes(expectData)) else begin
                    $display("CHECK FAILED at %0t: store %h to %h not expected",
                             $time, writedata, address);
                    errorCount++;
                end
                storage[address] = writedata;
            end
            #1;
            waitrequest = stallEnable && (($random(seed) & 3) == 0);
            readdata = wordAt(address);
        end
    end

endmodule

/* test/mipsCpuBusTb.sv */
`timescale 1ns/1ps

module mipsCpuBusTb import mipsPkg::*; ();

    logic clk;
    logic reset;
    logic stallEnable;
    logic active;
    wordT register_v0;
    wordT address;
    logic write;
    logic read;
    logic waitrequest;
    wordT writedata;
    logic [3:0] byteenable;
    wordT readdata;

    // Program table with code words, row bounds, expected v0 and expected store
    wordT code[$];
    int progStart[$];
    int progLen[$];
    wordT expectV0[$];
    wordT storeAddr[$];
    wordT storeData[$];
    int curStart = 0;
    int errors = 0;
    int cycles = 0;
    int cycleLimit;

    mipsCpuBus uut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    busMemory mem (
        .clk(clk),
        .stallEnable(stallEnable),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .readdata(readdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic wordT encodeR(logic [5:0] fn, int rs, int rt, int rd, int sh);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic wordT encodeI(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Jump to a word index of the program loaded at the reset vector
    function automatic wordT encodeJ(int idx);
        wordT target;
        target = resetVector + 32'(4 * idx);
        return {OP_J, target[27:2]};
    endfunction

    // Every program returns through JR to zero with a nop in the slot
    task automatic endProgram(input wordT v0, input wordT sAddr, input wordT sData);
        code.push_back(encodeR(FN_JR, 0, 0, 0, 0));
        code.push_back(32'h00000000);
        progStart.push_back(curStart);
        progLen.push_back(code.size() - curStart);
        expectV0.push_back(v0);
        storeAddr.push_back(sAddr);
        storeData.push_back(sData);
        curStart = code.size();
    endtask

    task automatic buildPrograms();
        // Register arithmetic and logic
        code.push_back(encodeI(OP_ADDIU, 0, 8, 'h1234));
        code.push_back(encodeI(OP_ADDIU, 0, 9, -16));
        code.push_back(encodeR(FN_SUBU, 8, 9, 10, 0));
        code.push_back(encodeR(FN_XOR, 10, 8, 11, 0));
        code.push_back(encodeR(FN_AND, 11, 8, 12, 0));
        code.push_back(encodeR(FN_OR, 12, 11, 13, 0));
        code.push_back(encodeR(FN_ADDU, 13, 10, 2, 0));
        endProgram(32'h000012B4, 32'h0, 32'h0);
        // Compares and shifts
        code.push_back(encodeI(OP_ADDIU, 0, 8, -1));
        code.push_back(encodeI(OP_ADDIU, 0, 9, 5));
        code.push_back(encodeR(FN_SLT, 8, 9, 10, 0));
        code.push_back(encodeR(FN_SLTU, 9, 8, 11, 0));
        code.push_back(encodeI(OP_LUI, 0, 15, 'h8000));
        code.push_back(encodeR(FN_SRA, 0, 15, 14, 4));
        code.push_back(encodeR(FN_SRL, 0, 15, 13, 28));
        code.push_back(encodeR(FN_SLL, 0, 11, 12, 4));
        code.push_back(encodeR(FN_ADDU, 14, 13, 2, 0));
        code.push_back(encodeR(FN_ADDU, 2, 12, 2, 0));
        code.push_back(encodeR(FN_ADDU, 2, 10, 2, 0));
        endProgram(32'hF8000019, 32'h0, 32'h0);
        // Immediates, zero and sign extension
        code.push_back(encodeI(OP_LUI, 0, 8, 'h1234));
        code.push_back(encodeI(OP_ORI, 8, 8, 'h8765));
        code.push_back(encodeI(OP_XORI, 8, 9, 'hFFFF));
        code.push_back(encodeI(OP_ANDI, 9, 10, 'hF0F0));
        code.push_back(encodeI(OP_ADDIU, 10, 11, 'h8000));
        code.push_back(encodeI(OP_SLTI, 10, 12, 'h8000));
        code.push_back(encodeI(OP_SLTIU, 11, 13, 'hF800));
        code.push_back(encodeR(FN_ADDU, 11, 13, 2, 0));
        code.push_back(encodeR(FN_ADDU, 2, 12, 2, 0));
        code.push_back(encodeR(FN_ADDU, 2, 9, 2, 0));
        endProgram(32'h1234692B, 32'h0, 32'h0);
        // Store then load with a negative offset
        code.push_back(encodeI(OP_ADDIU, 0, 8, 'h1010));
        code.push_back(encodeI(OP_LUI, 0, 9, 'hA1B2));
        code.push_back(encodeI(OP_ORI, 9, 9, 'hC3D4));
        code.push_back(encodeI(OP_SW, 8, 9, -8));
        code.push_back(encodeI(OP_LW, 8, 2, -8));
        endProgram(32'hA1B2C3D4, 32'h00001008, 32'hA1B2C3D4);
        // Branches and J where each bit of v0 marks one path
        code.push_back(encodeI(OP_ADDIU, 0, 8, 7));
        code.push_back(encodeI(OP_ADDIU, 0, 9, 7));
        code.push_back(encodeI(OP_BEQ, 8, 9, 2));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h1));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h2));
        code.push_back(encodeI(OP_BNE, 8, 9, 2));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h4));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h8));
        code.push_back(encodeI(OP_BNE, 8, 0, 2));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h10));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h20));
        code.push_back(encodeI(OP_BEQ, 8, 0, 2));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h40));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h80));
        code.push_back(encodeJ(17));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h100));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h200));
        code.push_back(encodeI(OP_ADDIU, 2, 2, 'h400));
        endProgram(32'h000005DD, 32'h0, 32'h0);
    endtask

    task automatic runProgram(input int p, input logic stalls);
        @(posedge clk);
        #1;
        reset = 1'b1;
        stallEnable = stalls;
        mem.clear();
        for (int k = 0; k < progLen[p]; k++) begin
            mem.loadWord(resetVector + 32'(4 * k), code[progStart[p] + k]);
        end
        mem.expectStore(storeAddr[p], storeData[p], storeAddr[p] != 32'h0);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (active && !write) else begin
            $display("CHECK FAILED at %0t: active %b write %b after reset", $time, active, write);
            errors++;
        end
        while (!read) @(negedge clk);
        assert (address == resetVector) else begin
            $display("CHECK FAILED at %0t: first fetch from %h", $time, address);
            errors++;
        end
        while (active) @(negedge clk);
        assert (register_v0 == expectV0[p]) else begin
            $display("CHECK FAILED at %0t: program %0d stalls %0d v0 %h, expected %h",
                     $time, p, stalls, register_v0, expectV0[p]);
            errors++;
        end
    endtask

    // Limit of 200 cycles per run with every program run with stalls off and on
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the core did not halt", cycles);
            $display("Errors: testbench %0d, memory %0d", errors, mem.errorCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        stallEnable = 1'b0;
        buildPrograms();
        cycleLimit = 200 * 2 * expectV0.size();
        for (int mode = 0; mode < 2; mode++) begin
            for (int p = 0; p < expectV0.size(); p++) begin
                runProgram(p, mode == 1);
            end
        end
        $display("Errors: testbench %0d, memory %0d", errors, mem.errorCount);
        if (errors == 0 && mem.errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
